// ==== logic/csc_pkg.sv ====
package csc_pkg;

	localparam int PIX_W = 8;

	// chroma samples kept for the six-tap filter
	localparam int HIST_DEPTH = 6;
	// pushes between a pair's arrival and its conversion
	localparam int LUMA_DELAY = 3;

	// interpolation taps, middle pair subtracted
	localparam int TAP_OUTER = 21;
	localparam int TAP_MID = 52;
	localparam int TAP_INNER = 159;

	// matrix coefficients, scaled by 2^16
	localparam int K_Y = 76284;
	localparam int K_RV = 104595;
	localparam int K_GU = 25624;
	localparam int K_GV = 53281;
	localparam int K_BU = 132251;

	localparam int Y_OFFSET = 16;
	localparam int C_OFFSET = 128;
	localparam int ROUND = 128;
	localparam int FIR_SHIFT = 8;
	localparam int MAT_SHIFT = 16;

	typedef struct packed {
		logic [PIX_W-1:0] even;
		logic [PIX_W-1:0] odd;
	} luma_pair_t;

	typedef struct packed {
		logic [PIX_W-1:0] u;
		logic [PIX_W-1:0] v;
	} chroma_t;

	// host word is {y_even, y_odd, u, v}
	typedef struct packed {
		luma_pair_t luma;
		chroma_t    chroma;
	} sample_t;

	typedef struct packed {
		logic [PIX_W-1:0] r;
		logic [PIX_W-1:0] g;
		logic [PIX_W-1:0] b;
	} rgb_t;

	typedef enum logic [3:0] {
		IDLE,
		SHIFT,
		FIR_U0,
		FIR_U1,
		FIR_V0,
		FIR_V1,
		MAT_E0,
		MAT_E1,
		MAT_O0,
		MAT_O1,
		DONE
	} step_t;

	// saturate a signed result into 0..255
	function automatic logic [PIX_W-1:0] clip8(input logic signed [31:0] x);
		logic [PIX_W-1:0] res;
		if (x < 0) begin
			res = '0;
		end else if (x > 255) begin
			res = '1;
		end else begin
			res = x[PIX_W-1:0];
		end
		return res;
	endfunction

endpackage

// ==== logic/apb_pkg.sv ====
package apb_pkg;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	// register map
	localparam logic [ADDR_W-1:0] REG_SAMPLE = 4'd0;
	localparam logic [ADDR_W-1:0] REG_RGB_EVEN = 4'd4;
	localparam logic [ADDR_W-1:0] REG_RGB_ODD = 4'd8;
	localparam logic [ADDR_W-1:0] REG_STATUS = 4'd12;

	// status bits
	localparam int ST_PRIMED = 0;
	localparam int ST_BUSY = 1;

endpackage

// ==== logic/csc_step_if.sv ====
// step code from the sequencer, odd chroma from the filter
interface csc_step_if;

	csc_pkg::step_t step;
	logic [csc_pkg::PIX_W-1:0] u_odd;
	logic [csc_pkg::PIX_W-1:0] v_odd;

	modport ctrl (
		output step
	);

	modport fir (
		input  step,
		output u_odd,
		output v_odd
	);

	modport mat (
		input step,
		input u_odd,
		input v_odd
	);

endinterface

// ==== logic/history_shift.sv ====
module history_shift #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH = 2
) (
	input  logic     Clock_50,
	input  logic     Resetn,
	input  logic     shift,
	input  payload_t din,
	// entry 0 holds the newest value
	output payload_t taps [DEPTH]
);

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (!Resetn) begin
			for (int i = 0; i < DEPTH; i++) begin
				taps[i] <= '0;
			end
		end else if (shift) begin
			taps[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

endmodule

// ==== logic/chroma_interp.sv ====
module chroma_interp (
	input  logic              Clock_50,
	input  logic              Resetn,
	input  csc_pkg::chroma_t  taps [csc_pkg::HIST_DEPTH],
	csc_step_if.fir           bus
);

	logic                      chan_v;
	logic                      phase1;
	logic [csc_pkg::PIX_W-1:0] s [csc_pkg::HIST_DEPTH];
	logic [csc_pkg::PIX_W-1:0] op_a;
	logic [csc_pkg::PIX_W-1:0] op_b;
	logic [csc_pkg::PIX_W-1:0] op_c;
	int                        coef_a;
	int                        coef_c;
	logic signed [19:0]        mul_a;
	logic signed [19:0]        mul_b;
	logic signed [19:0]        mul_c;
	logic signed [19:0]        prod_sum;
	logic signed [19:0]        partial;
	logic signed [19:0]        total;

	always_comb begin
		chan_v = (bus.step == csc_pkg::FIR_V0) || (bus.step == csc_pkg::FIR_V1);
		phase1 = (bus.step == csc_pkg::FIR_U1) || (bus.step == csc_pkg::FIR_V1);
		for (int i = 0; i < csc_pkg::HIST_DEPTH; i++) begin
			s[i] = chan_v ? taps[i].v : taps[i].u;
		end
		// oldest three first, then the newest three
		op_a = phase1 ? s[2] : s[5];
		op_b = phase1 ? s[1] : s[4];
		op_c = phase1 ? s[0] : s[3];
		coef_a = phase1 ? csc_pkg::TAP_INNER : csc_pkg::TAP_OUTER;
		coef_c = phase1 ? csc_pkg::TAP_OUTER : csc_pkg::TAP_INNER;
		mul_a = 20'(coef_a * $signed({1'b0, op_a}));
		mul_b = 20'(csc_pkg::TAP_MID * $signed({1'b0, op_b}));
		mul_c = 20'(coef_c * $signed({1'b0, op_c}));
		prod_sum = mul_a - mul_b + mul_c;
		total = partial + prod_sum + 20'(csc_pkg::ROUND);
	end

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (!Resetn) begin
			partial <= '0;
			bus.u_odd <= '0;
			bus.v_odd <= '0;
		end else begin
			case (bus.step)
				csc_pkg::FIR_U0, csc_pkg::FIR_V0: partial <= prod_sum;
				csc_pkg::FIR_U1: begin
					bus.u_odd <= csc_pkg::clip8(32'(total >>> csc_pkg::FIR_SHIFT));
				end
				csc_pkg::FIR_V1: begin
					bus.v_odd <= csc_pkg::clip8(32'(total >>> csc_pkg::FIR_SHIFT));
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== logic/yuv_to_rgb.sv ====
module yuv_to_rgb (
	input  logic                Clock_50,
	input  logic                Resetn,
	input  csc_pkg::luma_pair_t luma,
	input  csc_pkg::chroma_t    chroma,
	csc_step_if.mat             bus,
	output csc_pkg::rgb_t       rgb_even,
	output csc_pkg::rgb_t       rgb_odd
);

	logic                      odd_px;
	logic                      second;
	logic [csc_pkg::PIX_W-1:0] y_sel;
	logic [csc_pkg::PIX_W-1:0] u_sel;
	logic [csc_pkg::PIX_W-1:0] v_sel;
	logic signed [9:0]         y_d;
	logic signed [9:0]         u_d;
	logic signed [9:0]         v_d;
	logic signed [31:0]        mul_a;
	logic signed [31:0]        mul_b;
	logic signed [31:0]        mul_c;
	logic signed [31:0]        red_sum;
	logic signed [31:0]        green_sum;
	logic signed [31:0]        blue_sum;
	// kept from the first step of a pixel
	logic signed [31:0]        y_term;
	logic signed [31:0]        gu_term;

	always_comb begin
		odd_px = (bus.step == csc_pkg::MAT_O0) || (bus.step == csc_pkg::MAT_O1);
		second = (bus.step == csc_pkg::MAT_E1) || (bus.step == csc_pkg::MAT_O1);
		// odd pixel takes the interpolated chroma
		y_sel = odd_px ? luma.odd : luma.even;
		u_sel = odd_px ? bus.u_odd : chroma.u;
		v_sel = odd_px ? bus.v_odd : chroma.v;
		y_d = 10'($signed({2'b00, y_sel}) - csc_pkg::Y_OFFSET);
		u_d = 10'($signed({2'b00, u_sel}) - csc_pkg::C_OFFSET);
		v_d = 10'($signed({2'b00, v_sel}) - csc_pkg::C_OFFSET);
		// first step: luma, red v and green u; second step: green v and blue u
		mul_a = second ? csc_pkg::K_GV * v_d : csc_pkg::K_Y * y_d;
		mul_b = second ? csc_pkg::K_BU * u_d : csc_pkg::K_RV * v_d;
		mul_c = csc_pkg::K_GU * u_d;
		red_sum = mul_a + mul_b;
		green_sum = y_term - mul_a - gu_term;
		blue_sum = y_term + mul_b;
	end

	always_ff @(posedge Clock_50) begin
		if (bus.step == csc_pkg::MAT_E0 || bus.step == csc_pkg::MAT_O0) begin
			y_term <= mul_a;
			gu_term <= mul_c;
		end
	end

	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (!Resetn) begin
			rgb_even <= '0;
			rgb_odd <= '0;
		end else begin
			case (bus.step)
				csc_pkg::MAT_E0: rgb_even.r <= csc_pkg::clip8(red_sum >>> csc_pkg::MAT_SHIFT);
				csc_pkg::MAT_E1: begin
					rgb_even.g <= csc_pkg::clip8(green_sum >>> csc_pkg::MAT_SHIFT);
					rgb_even.b <= csc_pkg::clip8(blue_sum >>> csc_pkg::MAT_SHIFT);
				end
				csc_pkg::MAT_O0: rgb_odd.r <= csc_pkg::clip8(red_sum >>> csc_pkg::MAT_SHIFT);
				csc_pkg::MAT_O1: begin
					rgb_odd.g <= csc_pkg::clip8(green_sum >>> csc_pkg::MAT_SHIFT);
					rgb_odd.b <= csc_pkg::clip8(blue_sum >>> csc_pkg::MAT_SHIFT);
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== logic/csc_ctrl.sv ====
module csc_ctrl (
	input  logic     Clock_50,
	input  logic     Resetn,
	input  logic     push,
	output logic     busy,
	output logic     primed,
	csc_step_if.ctrl bus
);

	logic [1:0] push_cnt;

	// one step per cycle from SHIFT through DONE
	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (!Resetn) begin
			bus.step <= csc_pkg::IDLE;
		end else begin
			case (bus.step)
				csc_pkg::IDLE: begin
					if (push) begin
						bus.step <= csc_pkg::SHIFT;
					end
				end
				csc_pkg::DONE: bus.step <= csc_pkg::IDLE;
				default: bus.step <= csc_pkg::step_t'(bus.step + 4'd1);
			endcase
		end
	end

	assign busy = (bus.step != csc_pkg::IDLE);

	// history is full of real samples after three pushes
	always_ff @(posedge Clock_50 or negedge Resetn) begin
		if (!Resetn) begin
			push_cnt <= '0;
		end else if (push && push_cnt != 2'd3) begin
			push_cnt <= push_cnt + 2'd1;
		end
	end

	assign primed = (push_cnt == 2'd3);

	// bus side must hold off pushes during a conversion
	a_push_idle: assert property (@(posedge Clock_50) disable iff (!Resetn)
		push |-> bus.step == csc_pkg::IDLE);

	// a conversion runs to DONE without stalling
	a_shift_done: assert property (@(posedge Clock_50) disable iff (!Resetn)
		bus.step == csc_pkg::SHIFT |-> ##9 bus.step == csc_pkg::DONE);

endmodule

// ==== logic/apb_regs.sv ====
module apb_regs (
	input  logic                       Clock_50,
	input  logic                       Resetn,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [apb_pkg::ADDR_W-1:0] paddr,
	input  logic [apb_pkg::DATA_W-1:0] pwdata,
	input  logic                       busy,
	input  logic                       primed,
	input  csc_pkg::rgb_t              rgb_even,
	input  csc_pkg::rgb_t              rgb_odd,
	output logic [apb_pkg::DATA_W-1:0] prdata,
	output logic                       pready,
	output logic                       pslverr,
	output logic                       push,
	output csc_pkg::sample_t           sample
);

	logic                       access;
	logic                       hit_sample;
	logic                       hit_even;
	logic                       hit_odd;
	logic                       hit_status;
	logic                       bad_access;
	logic [apb_pkg::DATA_W-1:0] status;

	// wait states while a conversion runs
	assign pready = !busy;
	assign access = psel && penable && pready;

	assign hit_sample = (paddr == apb_pkg::REG_SAMPLE);
	assign hit_even = (paddr == apb_pkg::REG_RGB_EVEN);
	assign hit_odd = (paddr == apb_pkg::REG_RGB_ODD);
	assign hit_status = (paddr == apb_pkg::REG_STATUS);

	// unmapped address, or a write to a read-only register
	assign bad_access = !(hit_sample || hit_even || hit_odd || hit_status)
		|| (pwrite && !hit_sample);
	assign pslverr = access && bad_access;

	assign push = access && pwrite && hit_sample;
	assign sample = csc_pkg::sample_t'(pwdata);

	always_comb begin
		status = '0;
		status[apb_pkg::ST_PRIMED] = primed;
		status[apb_pkg::ST_BUSY] = busy;
	end

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (hit_even) begin
				prdata = {8'h00, rgb_even};
			end else if (hit_odd) begin
				prdata = {8'h00, rgb_odd};
			end else if (hit_status) begin
				prdata = status;
			end
		end
	end

	// accepted sample always starts the sequencer on the next edge
	a_push_starts: assert property (@(posedge Clock_50) disable iff (!Resetn)
		push |-> !busy ##1 busy);

endmodule

// ==== logic/csc_top.sv ====
module csc_top (
	input  logic                       Clock_50,
	input  logic                       Resetn,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [apb_pkg::ADDR_W-1:0] paddr,
	input  logic [apb_pkg::DATA_W-1:0] pwdata,
	output logic [apb_pkg::DATA_W-1:0] prdata,
	output logic                       pready,
	output logic                       pslverr
);

	logic                push;
	logic                busy;
	logic                primed;
	csc_pkg::sample_t    sample;
	csc_pkg::rgb_t       rgb_even;
	csc_pkg::rgb_t       rgb_odd;
	csc_pkg::chroma_t    chroma_taps [csc_pkg::HIST_DEPTH];
	// one stage past LUMA_DELAY so the oldest pair lines up with chroma tap 3
	csc_pkg::luma_pair_t luma_taps [csc_pkg::LUMA_DELAY+1];

	csc_step_if step_bus ();

	apb_regs i_apb_regs (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.busy     (busy),
		.primed   (primed),
		.rgb_even (rgb_even),
		.rgb_odd  (rgb_odd),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.push     (push),
		.sample   (sample)
	);

	csc_ctrl i_csc_ctrl (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.push     (push),
		.busy     (busy),
		.primed   (primed),
		.bus      (step_bus.ctrl)
	);

	history_shift #(
		.payload_t (csc_pkg::chroma_t),
		.DEPTH     (csc_pkg::HIST_DEPTH)
	) i_chroma_hist (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.shift    (push),
		.din      (sample.chroma),
		.taps     (chroma_taps)
	);

	history_shift #(
		.payload_t (csc_pkg::luma_pair_t),
		.DEPTH     (csc_pkg::LUMA_DELAY+1)
	) i_luma_hist (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.shift    (push),
		.din      (sample.luma),
		.taps     (luma_taps)
	);

	chroma_interp i_chroma_interp (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.taps     (chroma_taps),
		.bus      (step_bus.fir)
	);

	yuv_to_rgb i_yuv_to_rgb (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.luma     (luma_taps[csc_pkg::LUMA_DELAY]),
		.chroma   (chroma_taps[csc_pkg::LUMA_DELAY]),
		.bus      (step_bus.mat),
		.rgb_even (rgb_even),
		.rgb_odd  (rgb_odd)
	);

endmodule

// ==== testbench/tb_csc_top.sv ====
module tb_csc_top;

	localparam int CLK_HALF = 20;
	localparam int READY_TIMEOUT = 50;
	// a read right behind a push waits out the rest of the conversion
	localparam int STALL_AFTER_PUSH = 8;
	localparam int N_RANDOM = 12;
	localparam logic [1:0] CHK_NONE = 2'd0;
	localparam logic [1:0] CHK_RGB = 2'd1;
	localparam logic [1:0] CHK_STATUS = 2'd2;

	typedef struct packed {
		logic                       wr;
		logic [apb_pkg::ADDR_W-1:0] addr;
		logic [apb_pkg::DATA_W-1:0] data;
		logic                       err;
		logic [7:0]                 stall;
		logic [1:0]                 chk;
	} op_t;

	logic                       Clock_50 = 1'b0;
	logic                       Resetn;
	logic                       psel;
	logic                       penable;
	logic                       pwrite;
	logic [apb_pkg::ADDR_W-1:0] paddr;
	logic [apb_pkg::DATA_W-1:0] pwdata;
	logic [apb_pkg::DATA_W-1:0] prdata;
	logic                       pready;
	logic                       pslverr;

	logic [31:0]      lfsr;
	csc_pkg::sample_t pushed [$];
	op_t              ops [$];
	logic [31:0]      last_even;
	logic [31:0]      last_odd;
	logic [31:0]      last_status;
	int               errors;
	int               failed;
	logic             timed_out;

	csc_top i_dut (
		.Clock_50 (Clock_50),
		.Resetn   (Resetn),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr)
	);

	always #CLK_HALF Clock_50 = ~Clock_50;

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		if (s[0]) begin
			n = (s >> 1) ^ 32'h8020_0003;
		end else begin
			n = s >> 1;
		end
		return n;
	endfunction

	function automatic logic [31:0] random_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_next(lfsr);
			w = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic logic [7:0] clamp_px(input int x);
		logic [7:0] r;
		if (x < 0) begin
			r = 8'd0;
		end else if (x > 255) begin
			r = 8'd255;
		end else begin
			r = 8'(x);
		end
		return r;
	endfunction

	function automatic csc_pkg::rgb_t matrix_px(input int y, input int u, input int v);
		int            yd;
		int            ud;
		int            vd;
		csc_pkg::rgb_t px;
		yd = y - csc_pkg::Y_OFFSET;
		ud = u - csc_pkg::C_OFFSET;
		vd = v - csc_pkg::C_OFFSET;
		px.r = clamp_px((csc_pkg::K_Y * yd + csc_pkg::K_RV * vd) >>> csc_pkg::MAT_SHIFT);
		px.g = clamp_px((csc_pkg::K_Y * yd - csc_pkg::K_GU * ud - csc_pkg::K_GV * vd)
			>>> csc_pkg::MAT_SHIFT);
		px.b = clamp_px((csc_pkg::K_Y * yd + csc_pkg::K_BU * ud) >>> csc_pkg::MAT_SHIFT);
		return px;
	endfunction

	// zero before the first push
	function automatic csc_pkg::sample_t hist_at(input int k);
		csc_pkg::sample_t s;
		s = '0;
		if (k >= 0) begin
			s = pushed[k];
		end
		return s;
	endfunction

	// taps centred between pushes n-3 and n-2
	function automatic int interp_chroma(input int n, input logic v_chan);
		int               w [6];
		int               acc;
		csc_pkg::sample_t s;
		w = '{csc_pkg::TAP_OUTER, -csc_pkg::TAP_MID, csc_pkg::TAP_INNER,
			csc_pkg::TAP_INNER, -csc_pkg::TAP_MID, csc_pkg::TAP_OUTER};
		acc = csc_pkg::ROUND;
		for (int k = 0; k < 6; k++) begin
			s = hist_at(n - 5 + k);
			acc += w[k] * (v_chan ? int'(s.chroma.v) : int'(s.chroma.u));
		end
		return int'(clamp_px(acc >>> csc_pkg::FIR_SHIFT));
	endfunction

	task automatic add_op(input logic wr, input logic [apb_pkg::ADDR_W-1:0] addr,
		input logic [31:0] data, input logic err, input int stall, input logic [1:0] chk);
		op_t op;
		op.wr = wr;
		op.addr = addr;
		op.data = data;
		op.err = err;
		op.stall = 8'(stall);
		op.chk = chk;
		ops.push_back(op);
	endtask

	// one write then the three reads it should produce
	task automatic plan_push(input logic [31:0] word);
		int               n;
		csc_pkg::sample_t cur;
		csc_pkg::rgb_t    even_px;
		csc_pkg::rgb_t    odd_px;
		pushed.push_back(csc_pkg::sample_t'(word));
		n = pushed.size() - 1;
		cur = hist_at(n - 3);
		even_px = matrix_px(int'(cur.luma.even), int'(cur.chroma.u), int'(cur.chroma.v));
		odd_px = matrix_px(int'(cur.luma.odd), interp_chroma(n, 1'b0), interp_chroma(n, 1'b1));
		last_even = {8'h00, even_px};
		last_odd = {8'h00, odd_px};
		last_status = '0;
		last_status[apb_pkg::ST_PRIMED] = (n >= 2);
		add_op(1'b1, apb_pkg::REG_SAMPLE, word, 1'b0, 0, CHK_NONE);
		add_op(1'b0, apb_pkg::REG_RGB_EVEN, last_even, 1'b0, STALL_AFTER_PUSH, CHK_RGB);
		add_op(1'b0, apb_pkg::REG_RGB_ODD, last_odd, 1'b0, 0, CHK_RGB);
		add_op(1'b0, apb_pkg::REG_STATUS, last_status, 1'b0, 0, CHK_STATUS);
	endtask

	// bad accesses, then read back to see nothing moved
	task automatic plan_errors();
		add_op(1'b1, apb_pkg::REG_RGB_EVEN, 32'hFFFF_FFFF, 1'b1, 0, CHK_NONE);
		add_op(1'b1, 4'd2, 32'h1234_5678, 1'b1, 0, CHK_NONE);
		add_op(1'b0, 4'd2, 32'h0, 1'b1, 0, CHK_NONE);
		add_op(1'b0, apb_pkg::REG_RGB_EVEN, last_even, 1'b0, 0, CHK_RGB);
		add_op(1'b0, apb_pkg::REG_RGB_ODD, last_odd, 1'b0, 0, CHK_RGB);
		add_op(1'b0, apb_pkg::REG_STATUS, last_status, 1'b0, 0, CHK_STATUS);
	endtask

	task automatic check_rgb(input csc_pkg::rgb_t got, input csc_pkg::rgb_t exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_status(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("mismatch at %0t: %s was %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// setup, access, then hold until pready
	task automatic apb_xfer(input op_t op, output logic [31:0] rdata, output logic err,
		output int waits);
		@(posedge Clock_50);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= op.wr;
		paddr <= op.addr;
		pwdata <= op.wr ? op.data : '0;
		@(posedge Clock_50);
		penable <= 1'b1;
		waits = 0;
		@(negedge Clock_50);
		while (!pready && waits < READY_TIMEOUT) begin
			waits++;
			@(negedge Clock_50);
		end
		if (!pready) begin
			$display("timeout: pready stayed low for %0d cycles at time %0t", waits, $time);
			timed_out = 1'b1;
		end else begin
			rdata = prdata;
			err = pslverr;
			@(posedge Clock_50);
			psel <= 1'b0;
			penable <= 1'b0;
		end
	endtask

	initial begin
		logic [31:0] rdata;
		logic        err;
		int          waits;
		int          first_err;
		Resetn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsr = 32'h734039b9;
		errors = 0;
		failed = 0;
		timed_out = 1'b0;

		// everything reads zero straight out of reset
		add_op(1'b0, apb_pkg::REG_STATUS, 32'h0, 1'b0, 0, CHK_STATUS);
		add_op(1'b0, apb_pkg::REG_RGB_EVEN, 32'h0, 1'b0, 0, CHK_RGB);
		add_op(1'b0, apb_pkg::REG_RGB_ODD, 32'h0, 1'b0, 0, CHK_RGB);
		for (int i = 0; i < 3; i++) begin
			plan_push(random_word());
		end
		// full luma and V, then black, then blue and red-only corners
		repeat (6) plan_push(32'hFFFF_80FF);
		repeat (6) plan_push(32'h0000_8080);
		repeat (4) plan_push(32'hFFFF_FF00);
		repeat (4) plan_push(32'h0000_00FF);
		plan_errors();
		for (int i = 0; i < N_RANDOM; i++) begin
			plan_push(random_word());
		end

		repeat (2) @(posedge Clock_50);
		Resetn <= 1'b1;

		for (int i = 0; i < ops.size() && !timed_out; i++) begin
			first_err = errors;
			apb_xfer(ops[i], rdata, err, waits);
			if (!timed_out) begin
				check_count(int'(err), int'(ops[i].err), "pslverr");
				check_count(waits, int'(ops[i].stall), "wait states");
				if (ops[i].chk == CHK_RGB) begin
					check_rgb(csc_pkg::rgb_t'(rdata[23:0]), csc_pkg::rgb_t'(ops[i].data[23:0]),
						"rgb");
					check_count(int'(rdata[31:24]), 0, "rgb upper byte");
				end else if (ops[i].chk == CHK_STATUS) begin
					check_status(rdata, ops[i].data, "status");
				end
				if (errors != first_err) begin
					failed++;
				end
				$display("test %0d %s addr %0d: %s", i, ops[i].wr ? "write" : "read",
					ops[i].addr, (errors == first_err) ? "ok" : "failed");
			end
		end

		$display("%0d tests, %0d failed, %0d mismatches", ops.size(), failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/csc_pkg.sv
logic/apb_pkg.sv
logic/csc_step_if.sv
logic/history_shift.sv
logic/chroma_interp.sv
logic/yuv_to_rgb.sv
logic/csc_ctrl.sv
logic/apb_regs.sv
logic/csc_top.sv
testbench/tb_csc_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_csc_top -f vlog.f

out=$(./obj_dir/Vtb_csc_top)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'NO ERRORS'; then
	exit 0
else
	exit 1
fi
